/* Bender.yml */
package:
  name: long_pipe

sources:
  - include_dirs:
      - common
    files:
      - common/core_pkg.sv
      - hazard/hdu.sv
      - hdl/long_exu.sv
      - hdl/long_pipe_top.sv

  - target: simulation
    include_dirs:
      - common
    files:
      - tb/tb_long_pipe.sv

/* common/core_defs.svh */
//####################
// widths, slot count and latencies shared by the long-instruction pipe
// include in rtl and testbench files that size ports or counters
//####################
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// register and data widths
`define REG_ADDR_WIDTH 5    // x0..x31
`define XLEN 32             // rv32 data word

// scoreboard sizing, one commit id per slot
`define COMMIT_ID_WIDTH 2
`define LONG_SLOTS 4

// pipeline stall bus from the control unit
`define CU_BUS_WIDTH 4
`define CU_STALL_DISPATCH 1 // dispatch stage hold bit

// cycles from issue to ready
`define MUL_LATENCY 3
`define DIV_LATENCY 8       // divu and remu share the divider timing

`endif

/* common/core_pkg.sv */
//####################
// shared types of the long-instruction pipe
// referenced by scope as core_pkg::name, never imported
//####################
`include "core_defs.svh"

package core_pkg;

    // architectural register index
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    // tag of an outstanding long instruction
    typedef logic [`COMMIT_ID_WIDTH-1:0] commit_id_t;

    // operand / result word
    typedef logic [`XLEN-1:0] word_t;

    // long opcodes, signed division not supported
    typedef enum logic [1:0] {
        LOP_MUL  = 2'd0, // low half of product
        LOP_DIVU = 2'd1, // unsigned quotient
        LOP_REMU = 2'd2  // unsigned remainder
    } long_op_e;

endpackage

/* hazard/hdu.sv */
//####################
// hazard detection for long instructions
// tracks outstanding rd per commit id, flags raw / waw / full,
// holds a registered stall until the blocking entry retires,
// hands out the lowest free commit id and drives the atomic lock
//####################
`timescale 1ns/1ns
`include "core_defs.svh"

module hdu (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       new_long_inst_valid_i, // dispatch has a long inst
    input  core_pkg::reg_addr_t        new_inst_rd_addr_i,
    input  logic                       new_inst_rd_we_i,
    input  core_pkg::reg_addr_t        new_inst_rs1_addr_i,
    input  core_pkg::reg_addr_t        new_inst_rs2_addr_i,
    input  logic                       commit_valid_i,        // retire strobe from exu
    input  core_pkg::commit_id_t       commit_id_i,
    input  logic [`CU_BUS_WIDTH-1:0]   stall_flag_i,          // control unit stall bus
    output logic                       hazard_stall_o,
    output logic                       issue_fire_o,          // inst accepted this cycle
    output core_pkg::commit_id_t       alloc_id_o,            // lowest free id
    output logic                       long_inst_atom_lock_o
);

    // scoreboard state
    logic [`LONG_SLOTS-1:0]  valid_q;
    core_pkg::reg_addr_t     rd_q [`LONG_SLOTS]; // x0 when the inst does not write

    logic [`LONG_SLOTS-1:0]  commit_hit; // one-hot of the retiring slot
    logic [`LONG_SLOTS-1:0]  live;       // outstanding and not retiring now
    logic [`LONG_SLOTS-1:0]  free;

    logic                    rs1_chk;
    logic                    rs2_chk;
    logic                    rd_chk;
    logic                    raw_hazard;
    logic                    waw_hazard;
    logic                    full_hazard;
    logic                    hazard;
    core_pkg::commit_id_t    hazard_id;   // entry to wait on
    core_pkg::commit_id_t    hazard_id_q;
    logic                    stall_q;
    logic                    alloc_found;
    logic                    dispatch_stall;

    assign dispatch_stall = stall_flag_i[`CU_STALL_DISPATCH];

    // x0 never creates a dependency
    assign rs1_chk = (new_inst_rs1_addr_i != '0);
    assign rs2_chk = (new_inst_rs2_addr_i != '0);
    assign rd_chk  = (new_inst_rd_addr_i != '0) && new_inst_rd_we_i;

    always_comb begin
        for (int i = 0; i < `LONG_SLOTS; i++) begin
            commit_hit[i] = commit_valid_i && (commit_id_i == core_pkg::commit_id_t'(i));
        end
    end

    assign live = valid_q & ~commit_hit; // retiring entry already resolved
    assign free = ~live;

    // compare against every live entry, last match is recorded
    always_comb begin
        raw_hazard = 1'b0;
        waw_hazard = 1'b0;
        hazard_id  = '0; // full case waits on the lowest id
        for (int i = 0; i < `LONG_SLOTS; i++) begin
            if (live[i] && rd_q[i] != '0) begin
                if ((rs1_chk && new_inst_rs1_addr_i == rd_q[i]) ||
                    (rs2_chk && new_inst_rs2_addr_i == rd_q[i])) begin
                    raw_hazard = 1'b1;
                    hazard_id  = core_pkg::commit_id_t'(i);
                end
                if (rd_chk && new_inst_rd_addr_i == rd_q[i]) begin
                    waw_hazard = 1'b1;
                    hazard_id  = core_pkg::commit_id_t'(i);
                end
            end
        end
    end

    assign full_hazard = &live; // no slot frees up this cycle
    assign hazard      = new_long_inst_valid_i && (raw_hazard || waw_hazard || full_hazard);

    // lowest free id, a retiring slot can be reused at once
    always_comb begin
        alloc_id_o  = '0;
        alloc_found = 1'b0;
        for (int i = 0; i < `LONG_SLOTS; i++) begin
            if (free[i] && !alloc_found) begin
                alloc_id_o  = core_pkg::commit_id_t'(i);
                alloc_found = 1'b1;
            end
        end
    end

    assign issue_fire_o = new_long_inst_valid_i && !stall_q && !dispatch_stall && !hazard;

    // registered stall, released by the commit of the recorded id
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_q     <= 1'b0;
            hazard_id_q <= '0;
        end else if (!stall_q && !dispatch_stall && hazard) begin
            stall_q     <= 1'b1;
            hazard_id_q <= hazard_id;
        end else if (stall_q && commit_valid_i && (commit_id_i == hazard_id_q)) begin
            stall_q <= 1'b0; // lifts the cycle after commit
        end
    end

    assign hazard_stall_o = stall_q;

    // valid bits, set wins over clear on slot reuse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            for (int i = 0; i < `LONG_SLOTS; i++) begin
                if (commit_hit[i]) valid_q[i] <= 1'b0;
            end
            if (issue_fire_o) valid_q[alloc_id_o] <= 1'b1;
        end
    end

    // destination per slot
    always_ff @(posedge clk) begin
        if (issue_fire_o) begin
            rd_q[alloc_id_o] <= new_inst_rd_we_i ? new_inst_rd_addr_i : '0;
        end
    end

    assign long_inst_atom_lock_o = |valid_q; // anything still in flight

endmodule

/* hdl/long_exu.sv */
//####################
// long execution unit, one slot per commit id
// each slot counts down its opcode latency, ready slots wait
// and a fixed-priority arbiter retires the lowest id, one per cycle
//####################
`timescale 1ns/1ns
`include "core_defs.svh"

module long_exu (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue_valid_i, // accepted issue from hdu
    input  core_pkg::commit_id_t issue_id_i,    // slot to fill
    input  core_pkg::long_op_e   op_i,
    input  core_pkg::reg_addr_t  rd_addr_i,
    input  core_pkg::word_t      op_a_i,
    input  core_pkg::word_t      op_b_i,
    output logic                 commit_valid_o,
    output core_pkg::commit_id_t commit_id_o,
    output core_pkg::reg_addr_t  commit_rd_o,
    output core_pkg::word_t      commit_data_o
);

    localparam int CNT_W = $clog2(`DIV_LATENCY); // longest countdown fits

    // slot control
    logic [`LONG_SLOTS-1:0] busy_q;
    logic [CNT_W-1:0]       cnt_q [`LONG_SLOTS];
    logic [`LONG_SLOTS-1:0] ready;

    // slot payload
    core_pkg::long_op_e     op_q [`LONG_SLOTS];
    core_pkg::word_t        a_q  [`LONG_SLOTS];
    core_pkg::word_t        b_q  [`LONG_SLOTS];
    core_pkg::reg_addr_t    rd_q [`LONG_SLOTS];

    logic [CNT_W-1:0]       lat_init;
    core_pkg::commit_id_t   sel_id;
    logic                   sel_found;
    core_pkg::long_op_e     sel_op;
    core_pkg::word_t        sel_a;
    core_pkg::word_t        sel_b;

    // ready at issue + latency, so load latency minus one
    always_comb begin
        case (op_i)
            core_pkg::LOP_MUL: lat_init = CNT_W'(`MUL_LATENCY - 1);
            default:           lat_init = CNT_W'(`DIV_LATENCY - 1); // divu, remu
        endcase
    end

    always_comb begin
        for (int i = 0; i < `LONG_SLOTS; i++) begin
            ready[i] = busy_q[i] && (cnt_q[i] == '0);
        end
    end

    // fixed priority, lowest id first
    always_comb begin
        sel_id    = '0;
        sel_found = 1'b0;
        for (int i = 0; i < `LONG_SLOTS; i++) begin
            if (ready[i] && !sel_found) begin
                sel_id    = core_pkg::commit_id_t'(i);
                sel_found = 1'b1;
            end
        end
    end

    assign commit_valid_o = sel_found;
    assign commit_id_o    = sel_id;

    // countdown and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= '0;
            for (int i = 0; i < `LONG_SLOTS; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `LONG_SLOTS; i++) begin
                if (busy_q[i] && cnt_q[i] != '0) cnt_q[i] <= cnt_q[i] - 1'b1;
            end
            if (commit_valid_o) busy_q[sel_id] <= 1'b0; // retired
            if (issue_valid_i) begin                    // reuse overrides retire
                busy_q[issue_id_i] <= 1'b1;
                cnt_q[issue_id_i]  <= lat_init;
            end
        end
    end

    // operands captured at issue
    always_ff @(posedge clk) begin
        if (issue_valid_i) begin
            op_q[issue_id_i] <= op_i;
            a_q[issue_id_i]  <= op_a_i;
            b_q[issue_id_i]  <= op_b_i;
            rd_q[issue_id_i] <= rd_addr_i;
        end
    end

    // one shared datapath behind the arbiter
    assign sel_op      = op_q[sel_id];
    assign sel_a       = a_q[sel_id];
    assign sel_b       = b_q[sel_id];
    assign commit_rd_o = rd_q[sel_id];

    always_comb begin
        case (sel_op)
            core_pkg::LOP_MUL:  commit_data_o = sel_a * sel_b; // low 32 bits only
            core_pkg::LOP_DIVU: commit_data_o = (sel_b == '0) ? '1 : sel_a / sel_b;
            core_pkg::LOP_REMU: commit_data_o = (sel_b == '0) ? sel_a : sel_a % sel_b;
            default:            commit_data_o = '0;
        endcase
    end

endmodule

/* hdl/long_pipe_top.sv */
//####################
// long-instruction pipe top
// hdu gates issue and hands out ids, long_exu executes and retires
// commit feeds back into the hdu scoreboard
//####################
`timescale 1ns/1ns
`include "core_defs.svh"

module long_pipe_top (
    input  logic                     clk,
    input  logic                     rst_n,
    // issue side, held by the source until issue_fire_o
    input  logic                     new_long_inst_valid_i,
    input  core_pkg::long_op_e       long_op_i,
    input  core_pkg::reg_addr_t      rd_addr_i,
    input  logic                     rd_we_i,
    input  core_pkg::reg_addr_t      rs1_addr_i,
    input  core_pkg::reg_addr_t      rs2_addr_i,
    input  core_pkg::word_t          op_a_i,
    input  core_pkg::word_t          op_b_i,
    input  logic [`CU_BUS_WIDTH-1:0] stall_flag_i,
    // dispatch feedback
    output logic                     hazard_stall_o,
    output core_pkg::commit_id_t     commit_id_o,   // id of the current issue
    output logic                     issue_fire_o,
    output logic                     long_inst_atom_lock_o,
    // retire port
    output logic                     commit_valid_o,
    output core_pkg::commit_id_t     commit_id_o_c,
    output core_pkg::reg_addr_t      commit_rd_o,
    output core_pkg::word_t          commit_data_o
);

    hdu u_hdu (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .new_long_inst_valid_i (new_long_inst_valid_i),
        .new_inst_rd_addr_i    (rd_addr_i),
        .new_inst_rd_we_i      (rd_we_i),
        .new_inst_rs1_addr_i   (rs1_addr_i),
        .new_inst_rs2_addr_i   (rs2_addr_i),
        .commit_valid_i        (commit_valid_o), // retire frees the entry
        .commit_id_i           (commit_id_o_c),
        .stall_flag_i          (stall_flag_i),
        .hazard_stall_o        (hazard_stall_o),
        .issue_fire_o          (issue_fire_o),
        .alloc_id_o            (commit_id_o),
        .long_inst_atom_lock_o (long_inst_atom_lock_o)
    );

    long_exu u_long_exu (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_valid_i  (issue_fire_o),
        .issue_id_i     (commit_id_o), // slot = allocated id
        .op_i           (long_op_i),
        .rd_addr_i      (rd_addr_i),
        .op_a_i         (op_a_i),
        .op_b_i         (op_b_i),
        .commit_valid_o (commit_valid_o),
        .commit_id_o    (commit_id_o_c),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o)
    );

endmodule

/* project.f */
+incdir+common
common/core_pkg.sv
hazard/hdu.sv
hdl/long_exu.sv
hdl/long_pipe_top.sv
tb/tb_long_pipe.sv

/* tb/long_pipe_input.txt */
// op rd rd_we rs1 rs2 op_a op_b dispatch_stall expected, all hex
// op 0 mul, 1 divu, 2 remu; one instruction per line in issue order
0 01 1 00 00 00000003 00000005 0 0000000F
1 02 1 00 00 00000064 00000007 0 0000000E
2 03 1 00 00 00000064 00000007 0 00000002
0 04 1 00 00 00010000 00010000 0 00000000
1 05 1 00 00 00001234 00000000 0 FFFFFFFF
2 06 1 00 00 DEADBEEF 00000000 0 DEADBEEF
0 07 1 05 00 00000007 00000009 0 0000003F
1 08 1 00 00 FFFFFFFF 00000010 0 0FFFFFFF
0 08 1 00 00 12345678 00000010 0 23456780
0 00 1 00 00 0000FFFF 0000FFFF 0 FFFE0001
1 09 0 00 00 00000051 00000009 0 00000009
0 0A 1 09 00 00000002 00000003 0 00000006
2 0B 1 00 00 FFFFFFFF 0000000A 0 00000005
1 0C 1 0B 00 00000000 00000005 0 00000000
0 0D 1 00 00 80000000 00000002 0 00000000
0 0E 1 00 0D FFFFFFFF FFFFFFFF 0 00000001
1 0F 1 0E 00 000003E8 0000000A 1 00000064
2 10 1 00 00 000003E8 00000003 0 00000001
1 11 1 00 00 00000100 00000002 0 00000080
1 12 1 00 00 00000100 00000004 0 00000040
1 13 1 00 00 00000100 00000008 0 00000020
1 14 1 00 00 00000100 00000010 0 00000010
1 15 1 00 00 00000100 00000020 0 00000008
2 16 1 00 00 00000100 00000003 0 00000001
0 15 1 00 00 00000006 00000007 1 0000002A
0 17 1 16 00 00000011 00000011 0 00000121
1 18 1 00 00 00000007 00000007 0 00000001
2 19 1 00 00 00000007 00000007 0 00000000
2 1A 1 00 00 00000005 00000009 0 00000005
1 1B 1 00 00 00000005 00000009 0 00000000
0 1C 0 1A 00 00001000 00001000 0 01000000
1 1D 1 1C 00 00000010 00000000 1 FFFFFFFF
2 1E 1 00 1D 00000000 00000000 0 00000000
0 1F 1 00 00 0000000C 0000000B 0 00000084

/* tb/tb_long_pipe.sv */
//####################
// testbench for the long-instruction pipe
// replays tb/long_pipe_input.txt, keeps its own scoreboard model
// and checks ids, stalls, commit order, results and the lock every cycle
//####################
`timescale 1ns/1ns
`include "core_defs.svh"

module tb_long_pipe;

    localparam int NUM_VEC   = 34;
    localparam int FIELDS    = 9; // op rd we rs1 rs2 a b dstall exp
    localparam int WD_CYCLES = NUM_VEC * (`DIV_LATENCY + 4) + 50;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     new_long_inst_valid;
    core_pkg::long_op_e       long_op;
    core_pkg::reg_addr_t      rd_addr;
    logic                     rd_we;
    core_pkg::reg_addr_t      rs1_addr;
    core_pkg::reg_addr_t      rs2_addr;
    core_pkg::word_t          op_a;
    core_pkg::word_t          op_b;
    logic [`CU_BUS_WIDTH-1:0] stall_flag;

    logic                     hazard_stall;
    core_pkg::commit_id_t     alloc_id;
    logic                     issue_fire;
    logic                     atom_lock;
    logic                     commit_valid;
    core_pkg::commit_id_t     commit_id;
    core_pkg::reg_addr_t      commit_rd;
    core_pkg::word_t          commit_data;

    logic [31:0]              vec_mem [NUM_VEC*FIELDS];
    core_pkg::word_t          cur_exp; // expected result of the held inst

    // reference scoreboard
    logic [`LONG_SLOTS-1:0]   mdl_valid;
    core_pkg::reg_addr_t      mdl_rd [`LONG_SLOTS];   // x0 when rd not written
    core_pkg::reg_addr_t      exp_rd [`LONG_SLOTS];
    core_pkg::word_t          exp_data [`LONG_SLOTS];
    int                       ready_at [`LONG_SLOTS]; // cycle the slot may retire
    logic                     mdl_stall;
    core_pkg::commit_id_t     mdl_stall_id;

    int                       errors = 0;
    int                       checks = 0;
    int                       issues = 0;
    int                       commits = 0;
    int                       cyc = 0;     // monitored cycles since reset
    integer                   seed = 61;

    always #20 clk = ~clk; // 40 ns period

    long_pipe_top u_long_pipe_top (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .new_long_inst_valid_i (new_long_inst_valid),
        .long_op_i             (long_op),
        .rd_addr_i             (rd_addr),
        .rd_we_i               (rd_we),
        .rs1_addr_i            (rs1_addr),
        .rs2_addr_i            (rs2_addr),
        .op_a_i                (op_a),
        .op_b_i                (op_b),
        .stall_flag_i          (stall_flag),
        .hazard_stall_o        (hazard_stall),
        .commit_id_o           (alloc_id),
        .issue_fire_o          (issue_fire),
        .long_inst_atom_lock_o (atom_lock),
        .commit_valid_o        (commit_valid),
        .commit_id_o_c         (commit_id),
        .commit_rd_o           (commit_rd),
        .commit_data_o         (commit_data)
    );

    task automatic check_id(input string name, input core_pkg::commit_id_t got,
                            input core_pkg::commit_id_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input core_pkg::reg_addr_t got,
                             input core_pkg::reg_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input core_pkg::word_t got,
                              input core_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // sample mid-cycle while inputs are settled
    always @(negedge clk) begin : monitor
        logic [`LONG_SLOTS-1:0] hit;
        logic [`LONG_SLOTS-1:0] live;
        logic                   conflict;
        logic                   hz;
        logic                   exp_fire;
        logic                   got_free;
        logic                   dstall;
        logic                   exp_cv;
        core_pkg::commit_id_t   exp_cid;
        core_pkg::commit_id_t   cid;
        core_pkg::commit_id_t   exp_id;
        int                     lat;
        if (rst_n) begin
            check_bit("long_inst_atom_lock_o", atom_lock, |mdl_valid);
            check_bit("hazard_stall_o", hazard_stall, mdl_stall);
            exp_cv  = 1'b0;
            exp_cid = '0;
            for (int i = `LONG_SLOTS - 1; i >= 0; i--) begin
                if (mdl_valid[i] && cyc >= ready_at[i]) begin
                    exp_cv  = 1'b1;
                    exp_cid = core_pkg::commit_id_t'(i); // lowest ready retires
                end
            end
            check_bit("commit_valid_o", commit_valid, exp_cv);
            if (exp_cv) begin
                check_id("commit_id_o_c", commit_id, exp_cid);
            end
            hit = '0;
            if (commit_valid) begin
                commits++;
                hit[commit_id] = 1'b1;
                if (!mdl_valid[commit_id]) begin
                    errors++;
                    $display("commit of id %0d with no outstanding instruction", commit_id);
                end else begin
                    check_reg("commit_rd_o", commit_rd, exp_rd[commit_id]);
                    check_data("commit_data_o", commit_data, exp_data[commit_id]);
                end
            end
            live     = mdl_valid & ~hit; // retiring entry no longer blocks
            conflict = 1'b0;
            cid      = '0;
            for (int i = 0; i < `LONG_SLOTS; i++) begin
                if (live[i] && mdl_rd[i] != '0) begin
                    if ((rs1_addr != '0 && rs1_addr == mdl_rd[i]) ||
                        (rs2_addr != '0 && rs2_addr == mdl_rd[i]) ||
                        (rd_we && rd_addr != '0 && rd_addr == mdl_rd[i])) begin
                        conflict = 1'b1;
                        cid      = core_pkg::commit_id_t'(i);
                    end
                end
            end
            dstall   = stall_flag[`CU_STALL_DISPATCH];
            hz       = new_long_inst_valid && (conflict || &live);
            exp_fire = new_long_inst_valid && !mdl_stall && !dstall && !hz;
            check_bit("issue_fire_o", issue_fire, exp_fire);
            got_free = 1'b0;
            exp_id   = '0;
            for (int i = `LONG_SLOTS - 1; i >= 0; i--) begin
                if (!live[i]) begin
                    exp_id   = core_pkg::commit_id_t'(i); // lowest free wins
                    got_free = 1'b1;
                end
            end
            if (!mdl_stall && !dstall && hz) begin
                mdl_stall    = 1'b1;
                mdl_stall_id = conflict ? cid : '0; // full waits on id 0
            end else if (mdl_stall && commit_valid && commit_id == mdl_stall_id) begin
                mdl_stall = 1'b0;
            end
            mdl_valid = live;
            if (issue_fire) begin
                issues++;
                check_id("commit_id_o", alloc_id, exp_id);
                if (got_free) begin
                    lat = (long_op == core_pkg::LOP_MUL) ? `MUL_LATENCY : `DIV_LATENCY;
                    mdl_valid[exp_id] = 1'b1;
                    mdl_rd[exp_id]    = rd_we ? rd_addr : '0;
                    exp_rd[exp_id]    = rd_addr;
                    exp_data[exp_id]  = cur_exp;
                    ready_at[exp_id]  = cyc + lat;
                end
            end
            cyc++;
        end
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("timeout, pipe did not drain within %0d cycles", WD_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int   idle;
        int   held;
        int   base;
        logic accepted;
        rst_n               = 1'b0;
        new_long_inst_valid = 1'b0;
        long_op             = core_pkg::LOP_MUL;
        rd_addr             = '0;
        rd_we               = 1'b0;
        rs1_addr            = '0;
        rs2_addr            = '0;
        op_a                = '0;
        op_b                = '0;
        stall_flag          = '0;
        cur_exp             = '0;
        mdl_valid           = '0;
        mdl_stall           = 1'b0;
        mdl_stall_id        = '0;
        $readmemh("tb/long_pipe_input.txt", vec_mem);
        repeat (2) @(posedge clk);
        @(negedge clk); // outputs while in reset
        check_bit("hazard_stall_o", hazard_stall, 1'b0);
        check_bit("issue_fire_o", issue_fire, 1'b0);
        check_bit("commit_valid_o", commit_valid, 1'b0);
        check_bit("long_inst_atom_lock_o", atom_lock, 1'b0);
        @(posedge clk);
        #2 rst_n = 1'b1;
        for (int v = 0; v < NUM_VEC; v++) begin
            base                = v * FIELDS;
            idle                = {$random(seed)} % 3;
            new_long_inst_valid = 1'b0;
            repeat (idle) begin
                @(posedge clk);
                #2;
            end
            long_op  = core_pkg::long_op_e'(vec_mem[base][1:0]);
            rd_addr  = vec_mem[base+1][`REG_ADDR_WIDTH-1:0];
            rd_we    = vec_mem[base+2][0];
            rs1_addr = vec_mem[base+3][`REG_ADDR_WIDTH-1:0];
            rs2_addr = vec_mem[base+4][`REG_ADDR_WIDTH-1:0];
            op_a     = vec_mem[base+5];
            op_b     = vec_mem[base+6];
            stall_flag[`CU_STALL_DISPATCH] = vec_mem[base+7][0];
            cur_exp  = vec_mem[base+8];
            new_long_inst_valid = 1'b1;
            held     = 0;
            accepted = 1'b0;
            while (!accepted) begin // hold until the dut takes it
                @(negedge clk);
                accepted = issue_fire;
                @(posedge clk);
                #2;
                held++;
                if (held == 3) stall_flag[`CU_STALL_DISPATCH] = 1'b0; // dispatch hold over
            end
        end
        new_long_inst_valid = 1'b0;
        stall_flag          = '0;
        while (|mdl_valid) @(posedge clk);
        repeat (2) @(negedge clk);
        check_bit("long_inst_atom_lock_o", atom_lock, 1'b0);
        if (issues != NUM_VEC || commits != NUM_VEC) begin
            errors++;
            $display("not every instruction was issued and committed exactly once");
        end
        $display("checks %0d, errors %0d, issues %0d, commits %0d",
                 checks, errors, issues, commits);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
